// ==== Bender.yml ====
package:
  name: cq_axi_master

sources:
  - cq_pkg.sv
  - cq_demux.sv
  - cq_master_rd.sv
  - cq_master_wr.sv
  - pulse_merge.sv
  - cq_axi_master.sv
  - target: test
    files:
      - cq_axi_master_properties.sv
      - tb_cq_axi_master.sv

// ==== cq_axi_master.f ====
cq_pkg.sv
cq_demux.sv
cq_master_rd.sv
cq_master_wr.sv
pulse_merge.sv
cq_axi_master.sv
cq_axi_master_properties.sv
tb_cq_axi_master.sv

// ==== cq_axi_master.sv ====
`timescale 1ns/1ps

module cq_axi_master #(
    parameter int addr_width = 32,
    parameter int data_width = 32,
    parameter int tag_width  = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // Request stream.
    input  cq_pkg::req_type_e         req_type,
    input  logic [addr_width-1:0]     req_addr,
    input  logic [data_width/8-1:0]   req_be,
    input  logic [tag_width-1:0]      req_tag,
    input  logic [data_width-1:0]     req_data,
    input  logic                      req_valid,
    output logic                      req_ready,
    // Completion stream.
    output logic [tag_width-1:0]      cpl_tag,
    output logic [data_width-1:0]     cpl_data,
    output cq_pkg::cpl_status_e       cpl_status,
    output logic [15:0]               cpl_completer_id,
    output logic                      cpl_valid,
    input  logic                      cpl_ready,
    // AXI4-Lite master.
    output logic [addr_width-1:0]     awaddr,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [data_width-1:0]     wdata,
    output logic [data_width/8-1:0]   wstrb,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic [1:0]                bresp,
    input  logic                      bvalid,
    output logic                      bready,
    output logic [addr_width-1:0]     araddr,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [data_width-1:0]     rdata,
    input  logic [1:0]                rresp,
    input  logic                      rvalid,
    output logic                      rready,
    input  logic [15:0]               completer_id,
    output logic                      status_error_cor,
    output logic                      status_error_uncor
);
    localparam int count_width = 4;

    cq_pkg::req_type_e       rd_type;
    logic [addr_width-1:0]   rd_addr;
    logic [data_width/8-1:0] rd_be;
    logic [tag_width-1:0]    rd_tag;
    logic                    rd_valid;
    logic                    rd_ready;
    logic [addr_width-1:0]   wr_addr;
    logic [data_width/8-1:0] wr_be;
    logic [data_width-1:0]   wr_data;
    logic                    wr_valid;
    logic                    wr_ready;
    logic                    rd_error_uncor;
    logic                    wr_error_uncor;

    cq_demux #(
        .addr_width(addr_width),
        .data_width(data_width),
        .tag_width (tag_width)
    ) u_demux (.*);

    cq_master_rd #(
        .addr_width(addr_width),
        .data_width(data_width),
        .tag_width (tag_width)
    ) u_master_rd (
        .*,
        .error_uncor(rd_error_uncor)
    );

    cq_master_wr #(
        .addr_width(addr_width),
        .data_width(data_width)
    ) u_master_wr (
        .*,
        .error_uncor(wr_error_uncor)
    );

    // Both engines may fail in the same cycle.
    pulse_merge #(
        .in_width   (2),
        .count_width(count_width)
    ) u_error_merge (
        .clk      (clk),
        .rst_n    (rst_n),
        .pulse_in ({wr_error_uncor, rd_error_uncor}),
        .count_out(),
        .pulse_out(status_error_uncor)
    );

endmodule

// ==== cq_axi_master_properties.sv ====
`timescale 1ns/1ps

module cq_axi_master_properties #(
    parameter int addr_width = 32,
    parameter int data_width = 32,
    parameter int tag_width  = 8
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic [addr_width-1:0]   araddr,
    input logic                    arvalid,
    input logic                    arready,
    input logic [addr_width-1:0]   awaddr,
    input logic                    awvalid,
    input logic                    awready,
    input logic [data_width-1:0]   wdata,
    input logic [data_width/8-1:0] wstrb,
    input logic                    wvalid,
    input logic                    wready,
    input logic [tag_width-1:0]    cpl_tag,
    input logic [data_width-1:0]   cpl_data,
    input cq_pkg::cpl_status_e     cpl_status,
    input logic [15:0]             cpl_completer_id,
    input logic                    cpl_valid,
    input logic                    cpl_ready
);

    int fail_count = 0; // Property failures so far.

    // A raised valid holds with its payload until the transfer.
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fail_count++;
            $error("arvalid dropped or araddr changed before the AR transfer");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            fail_count++;
            $error("awvalid dropped or awaddr changed before the AW transfer");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            fail_count++;
            $error("wvalid dropped or W payload changed before the W transfer");
        end

    cpl_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl_tag) && $stable(cpl_data)
            && $stable(cpl_status) && $stable(cpl_completer_id))
        else begin
            fail_count++;
            $error("cpl_valid dropped or completion changed before its transfer");
        end

    // Reset is synchronous, so the valids are low from the edge after.
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !(arvalid || awvalid || wvalid || cpl_valid))
        else begin
            fail_count++;
            $error("a valid output was high during reset");
        end

endmodule

bind cq_axi_master cq_axi_master_properties #(
    .addr_width(addr_width),
    .data_width(data_width),
    .tag_width (tag_width)
) u_properties (.*);

// ==== cq_demux.sv ====
`timescale 1ns/1ps

module cq_demux #(
    parameter int addr_width = 32,
    parameter int data_width = 32,
    parameter int tag_width  = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cq_pkg::req_type_e         req_type,
    input  logic [addr_width-1:0]     req_addr,
    input  logic [data_width/8-1:0]   req_be,
    input  logic [tag_width-1:0]      req_tag,
    input  logic [data_width-1:0]     req_data,
    input  logic                      req_valid,
    output logic                      req_ready,
    output cq_pkg::req_type_e         rd_type,
    output logic [addr_width-1:0]     rd_addr,
    output logic [data_width/8-1:0]   rd_be,
    output logic [tag_width-1:0]      rd_tag,
    output logic                      rd_valid,
    input  logic                      rd_ready,
    output logic [addr_width-1:0]     wr_addr,
    output logic [data_width/8-1:0]   wr_be,
    output logic [data_width-1:0]     wr_data,
    output logic                      wr_valid,
    input  logic                      wr_ready
);
    import cq_pkg::*;

    logic full;     // Output register holds a request.
    logic route_wr; // Set for the write side.
    logic out_ready;

    assign out_ready = route_wr ? wr_ready : rd_ready;
    assign req_ready = !full || out_ready; // Empty, or occupant leaves this cycle.
    assign rd_valid  = full && !route_wr;
    assign wr_valid  = full && route_wr;

    // Both sides share the same payload register.
    assign wr_addr = rd_addr;
    assign wr_be   = rd_be;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (req_ready) begin
            full <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            route_wr <= (req_type == mem_wr);
            rd_type  <= req_type;
            rd_addr  <= req_addr;
            rd_be    <= req_be;
            rd_tag   <= req_tag;
            wr_data  <= req_data;
        end
    end

endmodule

// ==== cq_master_rd.sv ====
`timescale 1ns/1ps

module cq_master_rd #(
    parameter int addr_width = 32,
    parameter int data_width = 32,
    parameter int tag_width  = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cq_pkg::req_type_e         rd_type,
    input  logic [addr_width-1:0]     rd_addr,
    input  logic [data_width/8-1:0]   rd_be,
    input  logic [tag_width-1:0]      rd_tag,
    input  logic                      rd_valid,
    output logic                      rd_ready,
    output logic [addr_width-1:0]     araddr,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [data_width-1:0]     rdata,
    input  logic [1:0]                rresp,
    input  logic                      rvalid,
    output logic                      rready,
    output logic [tag_width-1:0]      cpl_tag,
    output logic [data_width-1:0]     cpl_data,
    output cq_pkg::cpl_status_e       cpl_status,
    output logic [15:0]               cpl_completer_id,
    output logic                      cpl_valid,
    input  logic                      cpl_ready,
    input  logic [15:0]               completer_id,
    output logic                      status_error_cor,
    output logic                      error_uncor
);
    import cq_pkg::*;

    localparam int be_width = data_width / 8;

    typedef enum logic [1:0] {idle, addr, data, cpl} state_e;

    state_e                state;
    logic [be_width-1:0]   be_q;         // Byte enables of the request in flight.
    logic [data_width-1:0] rdata_masked;

    assign rd_ready  = (state == idle);
    assign arvalid   = (state == addr);
    assign rready    = (state == data);
    assign cpl_valid = (state == cpl);

    // Disabled bytes read back as zero.
    always_comb begin
        for (int i = 0; i < be_width; i++) begin
            rdata_masked[8*i +: 8] = be_q[i] ? rdata[8*i +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state            <= idle;
            status_error_cor <= 1'b0;
            error_uncor      <= 1'b0;
        end else begin
            status_error_cor <= 1'b0;
            error_uncor      <= 1'b0;
            case (state)
                idle: begin
                    if (rd_valid) begin
                        if (rd_type == mem_rd) begin
                            state <= addr;
                        end else begin
                            state            <= cpl; // No bus access for these.
                            status_error_cor <= 1'b1;
                        end
                    end
                end
                addr:    if (arready) state <= data;
                data: begin
                    if (rvalid) begin
                        state       <= cpl;
                        error_uncor <= (rresp == slverr);
                    end
                end
                cpl:     if (cpl_ready) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) begin
            araddr           <= rd_addr;
            be_q             <= rd_be;
            cpl_tag          <= rd_tag;
            cpl_completer_id <= completer_id;
            cpl_data         <= '0;
            cpl_status       <= ur; // Replaced once read data returns.
        end
        if (rvalid && rready) begin
            cpl_data <= rdata_masked;
            if (rresp == slverr) begin
                cpl_status <= ca;
            end else begin
                cpl_status <= sc;
            end
        end
    end

endmodule

// ==== cq_master_wr.sv ====
`timescale 1ns/1ps

module cq_master_wr #(
    parameter int addr_width = 32,
    parameter int data_width = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [addr_width-1:0]     wr_addr,
    input  logic [data_width/8-1:0]   wr_be,
    input  logic [data_width-1:0]     wr_data,
    input  logic                      wr_valid,
    output logic                      wr_ready,
    output logic [addr_width-1:0]     awaddr,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [data_width-1:0]     wdata,
    output logic [data_width/8-1:0]   wstrb,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic [1:0]                bresp,
    input  logic                      bvalid,
    output logic                      bready,
    output logic                      error_uncor
);
    import cq_pkg::*;

    typedef enum logic [1:0] {idle, xfer, resp} state_e;

    state_e state;
    logic   aw_done;    // AW already transferred.
    logic   w_done;     // W already transferred.
    logic   aw_fire;
    logic   w_fire;

    assign wr_ready = (state == idle);
    assign awvalid  = (state == xfer) && !aw_done;
    assign wvalid   = (state == xfer) && !w_done;
    assign bready   = (state == resp);
    assign aw_fire  = awvalid && awready;
    assign w_fire   = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= idle;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            error_uncor <= 1'b0;
        end else begin
            error_uncor <= 1'b0;
            case (state)
                idle: begin
                    if (wr_valid) begin
                        state   <= xfer;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                xfer: begin
                    if (aw_fire) aw_done <= 1'b1;
                    if (w_fire) w_done <= 1'b1;
                    // AW and W may finish in either order.
                    if ((aw_done || aw_fire) && (w_done || w_fire)) state <= resp;
                end
                resp: begin
                    if (bvalid) begin
                        state       <= idle;
                        error_uncor <= (bresp == slverr); // Posted, so only a status pulse.
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && wr_ready) begin
            awaddr <= wr_addr;
            wdata  <= wr_data;
            wstrb  <= wr_be;
        end
    end

endmodule

// ==== cq_pkg.sv ====
package cq_pkg;

    // Request type field in CQ descriptor encoding.
    typedef enum logic [3:0] {
        mem_rd = 4'b0000, // Memory read.
        mem_wr = 4'b0001, // Posted memory write.
        io_rd  = 4'b0010,
        io_wr  = 4'b0011,
        msg    = 4'b1100
    } req_type_e;

    // Completion status codes.
    typedef enum logic [2:0] {
        sc = 3'b000, // Successful completion.
        ur = 3'b001, // Unsupported request.
        ca = 3'b100  // Completer abort.
    } cpl_status_e;

    // Bus response codes for B and R channels.
    localparam logic [1:0] okay   = 2'b00;
    localparam logic [1:0] slverr = 2'b10;

endpackage

// ==== pulse_merge.sv ====
`timescale 1ns/1ps

module pulse_merge #(
    parameter int in_width    = 2,
    parameter int count_width = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [in_width-1:0]    pulse_in,
    output logic [count_width-1:0] count_out,
    output logic                   pulse_out
);
    localparam int ones_width = $clog2(in_width + 1);
    localparam int sum_width  = count_width + ones_width;
    localparam logic [sum_width-1:0] count_max = {count_width{1'b1}};

    logic [ones_width-1:0] ones;      // Events arriving this cycle.
    logic [sum_width-1:0]  total;
    logic [sum_width-1:0]  remaining; // Left after this cycle's output pulse.

    always_comb begin
        ones = '0;
        for (int i = 0; i < in_width; i++) begin
            ones = ones + ones_width'(pulse_in[i]);
        end
        total     = sum_width'(count_out) + sum_width'(ones);
        remaining = (total == '0) ? '0 : total - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_out <= '0;
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= (total != '0);
            count_out <= (remaining > count_max) ? count_max[count_width-1:0] // Saturate.
                                                 : remaining[count_width-1:0];
        end
    end

endmodule

// ==== tb_cq_axi_master.sv ====
`timescale 1ns/1ps

module tb_cq_axi_master;
    import cq_pkg::*;

    localparam logic [31:0] bad_addr = 32'h0000_003c; // Top word answers with slverr.
    localparam logic [15:0] my_id    = 16'h01a5;
    localparam int          limit    = 400;           // Cycles allowed for any wait.

    logic        clk;
    logic        rst_n;
    req_type_e   req_type;
    logic [31:0] req_addr;
    logic [3:0]  req_be;
    logic [7:0]  req_tag;
    logic [31:0] req_data;
    logic        req_valid, req_ready;
    logic [7:0]  cpl_tag;
    logic [31:0] cpl_data;
    cpl_status_e cpl_status;
    logic [15:0] cpl_completer_id, completer_id;
    logic        cpl_valid, cpl_ready;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic        status_error_cor, status_error_uncor;

    logic [31:0] mem [16];     // Bus memory model.
    logic [31:0] ref_mem [16]; // What the memory should hold.
    logic [31:0] ar_addr_q, aw_addr_q, w_data_q;
    logic [3:0]  w_strb_q;
    logic        ar_pend, aw_pend, w_pend;
    logic        sync_errors;  // Release R and B in the same cycle.

    // Expected completions in request order.
    logic [7:0]  exp_tag[$];
    cpl_status_e exp_status[$];
    logic [31:0] exp_data[$];
    logic [7:0]  e_tag;
    cpl_status_e e_status;
    logic [31:0] e_data;
    logic [7:0]  next_tag;
    logic [31:0] r_addr, r_data;
    logic [3:0]  r_be;
    int          ar_count, ar_at_cpl, b_count, cor_count, uncor_count;
    int          wr_issued, exp_cor, settle;

    cq_axi_master u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] init_word(input int idx);
        return 32'h5a00_0000 ^ (idx * 32'h0103_0507);
    endfunction

    // Replace the enabled bytes of a word.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] upd,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[8*i +: 8] = upd[8*i +: 8];
        end
        return res;
    endfunction

    task automatic stop_run;
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic abort_with(input string what);
        $display("%s at time %0t", what, $time);
        stop_run();
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("error: time %0t, %s is 'h%0h, expected 'h%0h", $time, name, got, exp);
        stop_run();
    endtask

    // Wait for outstanding reads, writes or both.
    task automatic drain(input bit reads, input bit writes);
        int waited;
        waited = 0;
        while ((reads && exp_tag.size() != 0) || (writes && b_count != wr_issued)) begin
            @(negedge clk);
            waited++;
            if (waited > limit) abort_with("outstanding requests did not finish");
        end
    endtask

    task automatic send_request(input req_type_e t, input logic [31:0] a, input logic [3:0] be,
                                input logic [31:0] d);
        int   waited;
        logic taken;
        waited    = 0;
        taken     = 1'b0;
        req_type  = t;
        req_addr  = a;
        req_be    = be;
        req_data  = d;
        req_tag   = next_tag;
        req_valid = 1'b1;
        while (!taken) begin
            @(posedge clk);
            taken = req_ready;
            waited++;
            if (waited > limit) abort_with("request was never accepted");
            @(negedge clk);
        end
        req_valid = 1'b0;
        next_tag  = next_tag + 8'd1;
    endtask

    task automatic post_write(input logic [31:0] a, input logic [3:0] be, input logic [31:0] d);
        if (a != bad_addr) begin
            drain(1'b1, 1'b0); // A read in flight could see either value.
            ref_mem[a[5:2]] = merge_bytes(ref_mem[a[5:2]], d, be);
        end
        wr_issued++;
        send_request(mem_wr, a, be, d);
    endtask

    task automatic issue_read(input req_type_e t, input logic [31:0] a, input logic [3:0] be);
        if (a != bad_addr) drain(1'b0, 1'b1);
        exp_tag.push_back(next_tag);
        if (t != mem_rd) begin
            exp_status.push_back(ur);
            exp_data.push_back(32'h0);
            exp_cor++;
        end else if (a == bad_addr) begin
            exp_status.push_back(ca);
            exp_data.push_back(32'h0);
        end else begin
            exp_status.push_back(sc);
            exp_data.push_back(merge_bytes(32'h0, ref_mem[a[5:2]], be));
        end
        send_request(t, a, be, 32'h0);
    endtask

    task automatic check_completion;
        if (exp_tag.size() == 0) abort_with("a completion arrived with no read outstanding");
        e_tag    = exp_tag.pop_front();
        e_status = exp_status.pop_front();
        e_data   = exp_data.pop_front();
        assert (cpl_tag == e_tag) else mismatch("cpl_tag", cpl_tag, e_tag);
        assert (cpl_completer_id == my_id)
            else mismatch("cpl_completer_id", cpl_completer_id, my_id);
        assert (cpl_status == e_status) else mismatch("cpl_status", cpl_status, e_status);
        if (e_status != ca) begin
            assert (cpl_data == e_data) else mismatch("cpl_data", cpl_data, e_data);
        end
        // Reads finish one at a time, so any AR since the last completion is this one's.
        if (e_status == ur) begin
            assert (ar_count == ar_at_cpl)
                else abort_with("a bus read was issued for an unsupported request");
        end
        ar_at_cpl = ar_count;
    endtask

    // Transfer monitor.
    always @(posedge clk) begin
        if (rst_n) begin
            if (arvalid && arready) begin
                ar_pend   = 1'b1;
                ar_addr_q = araddr;
                ar_count++;
            end
            if (rvalid && rready) ar_pend = 1'b0;
            if (awvalid && awready) begin
                aw_pend   = 1'b1;
                aw_addr_q = awaddr;
            end
            if (wvalid && wready) begin
                w_pend   = 1'b1;
                w_data_q = wdata;
                w_strb_q = wstrb;
            end
            if (bvalid && bready) begin
                aw_pend = 1'b0;
                w_pend  = 1'b0;
                b_count++;
            end
            if (status_error_cor) cor_count++;
            if (status_error_uncor) uncor_count++;
            if (cpl_valid && cpl_ready) check_completion();
        end
    end

    // A failed bound property ends the run.
    always @(negedge clk) begin
        if (u_dut.u_properties.fail_count != 0) begin
            abort_with("a bound handshake or reset property failed");
        end
    end

    // Bus responder with random stalls.
    always @(negedge clk) begin
        if (rst_n) begin
            arready   = ($urandom % 3) != 0;
            awready   = ($urandom % 3) != 0;
            wready    = ($urandom % 3) != 0;
            cpl_ready = ($urandom % 4) != 0;
            if (!ar_pend) begin
                rvalid = 1'b0;
            end else if (!rvalid && (sync_errors ? (aw_pend && w_pend) : ($urandom % 2) == 0)) begin
                rvalid = 1'b1;
                rresp  = (ar_addr_q == bad_addr) ? slverr : okay;
                rdata  = (ar_addr_q == bad_addr) ? 32'hdead_dead : mem[ar_addr_q[5:2]];
            end
            if (!(aw_pend && w_pend)) begin
                bvalid = 1'b0;
            end else if (!bvalid && (!sync_errors || ar_pend)) begin
                bvalid = 1'b1;
                bresp  = (aw_addr_q == bad_addr) ? slverr : okay;
                if (aw_addr_q != bad_addr) begin
                    mem[aw_addr_q[5:2]] = merge_bytes(mem[aw_addr_q[5:2]], w_data_q, w_strb_q);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hb543_562e));
        clk = 1'b0;
        rst_n = 1'b0;
        req_type = mem_rd;
        req_addr = '0;
        req_be = '0;
        req_tag = '0;
        req_data = '0;
        req_valid = 1'b0;
        cpl_ready = 1'b0;
        completer_id = my_id;
        {awready, wready, bvalid, arready, rvalid} = '0;
        {bresp, rresp, rdata} = '0;
        {ar_pend, aw_pend, w_pend, sync_errors} = '0;
        {ar_count, ar_at_cpl, b_count, cor_count, uncor_count} = '0;
        {wr_issued, exp_cor, settle} = '0;
        next_tag = 8'h40;
        for (int i = 0; i < 16; i++) begin
            mem[i]     = init_word(i);
            ref_mem[i] = init_word(i);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Partial writes read back through full and partial enables.
        post_write(32'h10, 4'b0101, 32'h1122_3344);
        issue_read(mem_rd, 32'h10, 4'b1111);
        post_write(32'h04, 4'b1000, 32'hff00_0000);
        issue_read(mem_rd, 32'h04, 4'b1001);
        // Unsupported types mixed with a normal read.
        issue_read(io_rd, 32'h08, 4'b1111);
        issue_read(mem_rd, 32'h08, 4'b1111);
        issue_read(msg, 32'h00, 4'b1111);
        issue_read(io_wr, 32'h0c, 4'b0011);
        // Both engines hit the reserved word and their errors land together.
        drain(1'b1, 1'b1);
        sync_errors = 1'b1;
        issue_read(mem_rd, bad_addr, 4'b1111);
        post_write(bad_addr, 4'b1111, 32'h0bad_0bad);
        drain(1'b1, 1'b1);
        sync_errors = 1'b0;
        for (int n = 0; n < 40; n++) begin
            r_addr = 32'(($urandom % 15) * 4);
            r_be   = 4'($urandom % 15 + 1);
            r_data = $urandom;
            if ($urandom % 3 == 0) begin
                post_write(r_addr, r_be, r_data);
            end else begin
                issue_read(mem_rd, r_addr, r_be);
            end
        end
        drain(1'b1, 1'b1);

        while (cor_count < exp_cor || uncor_count < 2) begin
            @(negedge clk);
            settle++;
            if (settle > limit) abort_with("status pulses did not all arrive");
        end
        repeat (3) @(negedge clk); // Room for a stray extra pulse.
        assert (cor_count == exp_cor) else mismatch("status_error_cor count", cor_count, exp_cor);
        assert (uncor_count == 2) else mismatch("status_error_uncor count", uncor_count, 2);
        if (u_dut.u_properties.fail_count != 0) begin
            abort_with("a bound handshake or reset property failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule
